// ==== Bender.yml ====
package:
  name: cache_subsystem

sources:
  - files:
      - rtl/cache_pkg.sv
      - rtl/read_cache.sv
      - rtl/mem_arbiter.sv
      - rtl/cache_subsystem.sv
  - target: simulation
    files:
      - sim/mem_model.sv
      - sim/tb_cache_subsystem.sv

// ==== flist.f ====
rtl/cache_pkg.sv
rtl/read_cache.sv
rtl/mem_arbiter.sv
rtl/cache_subsystem.sv
sim/mem_model.sv
sim/tb_cache_subsystem.sv

// ==== rtl/cache_pkg.sv ====
package cache_pkg;

    // geometry of one cache.
    localparam int ADDR_W      = 32;
    localparam int WORD_W      = 32;
    localparam int CACHE_BYTES = 8192;
    localparam int LINE_BITS   = 128;
    localparam int NUM_LINES   = CACHE_BYTES * 8 / LINE_BITS;
    localparam int INDEX_W     = $clog2(NUM_LINES);
    localparam int OFFSET_W    = $clog2(LINE_BITS / WORD_W);
    localparam int BYTE_OFF_W  = $clog2(WORD_W / 8);
    localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;

    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [INDEX_W-1:0]   index_t;
    typedef logic [OFFSET_W-1:0]  offset_t;

    // processor side of one cache.
    typedef struct packed {
        logic  read_en;
        addr_t addr;
    } cpu_req_t;

    typedef struct packed {
        logic  data_valid;
        logic  hit;
        logic  busy;
        word_t data;
    } cpu_rsp_t;

    // line refill port towards main memory.
    typedef struct packed {
        logic  req;
        addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic  ready;
        line_t data;
    } mem_rsp_t;

    typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, RESPOND} cache_state_t;

    typedef enum logic [1:0] {ARB_IDLE, ARB_ICACHE, ARB_DCACHE} arb_state_t;

endpackage

// ==== rtl/cache_subsystem.sv ====
`timescale 1ns/10ps

module cache_subsystem (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  cache_pkg::cpu_req_t icache_req,
    output cache_pkg::cpu_rsp_t icache_rsp,
    input  cache_pkg::cpu_req_t dcache_req,
    output cache_pkg::cpu_rsp_t dcache_rsp,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp
);

    // refill traffic between each cache and the arbiter.
    cache_pkg::mem_req_t icache_mem_req;
    cache_pkg::mem_rsp_t icache_mem_rsp;
    cache_pkg::mem_req_t dcache_mem_req;
    cache_pkg::mem_rsp_t dcache_mem_rsp;

    read_cache u_icache (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .cpu_req (icache_req),
        .cpu_rsp (icache_rsp),
        .mem_req (icache_mem_req),
        .mem_rsp (icache_mem_rsp)
    );

    read_cache u_dcache (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .cpu_req (dcache_req),
        .cpu_rsp (dcache_rsp),
        .mem_req (dcache_mem_req),
        .mem_rsp (dcache_mem_rsp)
    );

    // the arbiter is the only driver of the external memory port.
    mem_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .icache_req (icache_mem_req),
        .dcache_req (dcache_mem_req),
        .icache_rsp (icache_mem_rsp),
        .dcache_rsp (dcache_mem_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

endmodule

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::mem_req_t icache_req,
    input  cache_pkg::mem_req_t dcache_req,
    output cache_pkg::mem_rsp_t icache_rsp,
    output cache_pkg::mem_rsp_t dcache_rsp,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp
);

    cache_pkg::arb_state_t state;
    cache_pkg::arb_state_t state_next;

    // set when the last contested grant went to the data cache.
    logic last_dcache;
    logic last_dcache_next;

    cache_pkg::mem_req_t req_q;
    cache_pkg::mem_req_t req_next;

    logic contested;
    logic pick_dcache;

    assign contested = icache_req.req && dcache_req.req;

    // only a contest moves the priority, so an uncontested grant keeps the turn order.
    assign pick_dcache = contested ? !last_dcache : dcache_req.req;

    always_comb begin
        state_next       = state;
        last_dcache_next = last_dcache;
        req_next         = req_q;
        case (state)
            cache_pkg::ARB_IDLE: begin
                if (icache_req.req || dcache_req.req) begin
                    state_next = pick_dcache ? cache_pkg::ARB_DCACHE : cache_pkg::ARB_ICACHE;
                    req_next   = pick_dcache ? dcache_req : icache_req;
                    if (contested) begin
                        last_dcache_next = pick_dcache;
                    end
                end
            end
            cache_pkg::ARB_ICACHE: begin
                if (mem_rsp.ready) begin
                    state_next   = cache_pkg::ARB_IDLE;
                    req_next.req = 1'b0;
                end else begin
                    req_next = icache_req;
                end
            end
            cache_pkg::ARB_DCACHE: begin
                if (mem_rsp.ready) begin
                    state_next   = cache_pkg::ARB_IDLE;
                    req_next.req = 1'b0;
                end else begin
                    req_next = dcache_req;
                end
            end
            default: begin
                state_next   = cache_pkg::ARB_IDLE;
                req_next.req = 1'b0;
            end
        endcase
    end

    // the instruction cache wins the first contest after reset.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= cache_pkg::ARB_IDLE;
            last_dcache <= 1'b1;
            req_q       <= '0;
        end else begin
            state       <= state_next;
            last_dcache <= last_dcache_next;
            req_q       <= req_next;
        end
    end

    assign mem_req = req_q;

    // ready and data reach the owner only.
    always_comb begin
        icache_rsp.ready = mem_rsp.ready && (state == cache_pkg::ARB_ICACHE);
        icache_rsp.data  = (state == cache_pkg::ARB_ICACHE) ? mem_rsp.data : '0;
        dcache_rsp.ready = mem_rsp.ready && (state == cache_pkg::ARB_DCACHE);
        dcache_rsp.data  = (state == cache_pkg::ARB_DCACHE) ? mem_rsp.data : '0;
    end

endmodule

// ==== rtl/read_cache.sv ====
`timescale 1ns/10ps

module read_cache (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  cache_pkg::cpu_req_t cpu_req,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp
);

    // one storage entry holds the tag next to its line.
    typedef struct packed {
        cache_pkg::tag_t  tag;
        cache_pkg::line_t line;
    } entry_t;

    entry_t                          entry_mem [cache_pkg::NUM_LINES];
    logic [cache_pkg::NUM_LINES-1:0] valid;

    cache_pkg::cache_state_t state;
    cache_pkg::cache_state_t state_next;

    cache_pkg::tag_t    req_tag;
    cache_pkg::index_t  req_index;
    cache_pkg::offset_t req_offset;

    cache_pkg::tag_t    tag_q;
    cache_pkg::index_t  index_q;
    cache_pkg::offset_t offset_q;

    entry_t             rd_entry;
    logic               accept;
    logic               lookup_hit;
    logic               refill_done;
    logic               hit_q;
    cache_pkg::word_t   data_q;

    function automatic cache_pkg::word_t select_word(
        input cache_pkg::line_t   line,
        input cache_pkg::offset_t offset
    );
        return line[offset * cache_pkg::WORD_W +: cache_pkg::WORD_W];
    endfunction

    // split the byte address; the two lowest bits are dropped.
    assign req_offset = cpu_req.addr[cache_pkg::BYTE_OFF_W +: cache_pkg::OFFSET_W];
    assign req_index  = cpu_req.addr[cache_pkg::BYTE_OFF_W + cache_pkg::OFFSET_W +:
                                     cache_pkg::INDEX_W];
    assign req_tag    = cpu_req.addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];

    // a new strobe is taken when idle or while the previous answer is on the port.
    assign accept = cpu_req.read_en &&
                    ((state == cache_pkg::IDLE) || (state == cache_pkg::RESPOND));

    assign lookup_hit  = valid[index_q] && (rd_entry.tag == tag_q);
    assign refill_done = (state == cache_pkg::REFILL) && mem_rsp.ready;

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::IDLE,
            cache_pkg::RESPOND: begin
                state_next = accept ? cache_pkg::LOOKUP : cache_pkg::IDLE;
            end
            cache_pkg::LOOKUP: begin
                state_next = lookup_hit ? cache_pkg::RESPOND : cache_pkg::REFILL;
            end
            cache_pkg::REFILL: begin
                if (mem_rsp.ready) begin
                    state_next = cache_pkg::RESPOND;
                end
            end
            default: begin
                state_next = cache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= cache_pkg::IDLE;
            hit_q <= 1'b0;
        end else begin
            state <= state_next;
            if (state == cache_pkg::LOOKUP) begin
                hit_q <= lookup_hit;
            end
        end
    end

    // flush and a refill may land on the same edge; the refilled line stays valid.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
        end else begin
            if (flush) begin
                valid <= '0;
            end
            if (refill_done) begin
                valid[index_q] <= 1'b1;
            end
        end
    end

    // line and tag storage, read on accept and written when the refill arrives.
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_entry <= entry_mem[req_index];
        end
        if (refill_done) begin
            entry_mem[index_q] <= '{tag: tag_q, line: mem_rsp.data};
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tag_q    <= req_tag;
            index_q  <= req_index;
            offset_q <= req_offset;
        end
        if (state == cache_pkg::LOOKUP) begin
            data_q <= select_word(rd_entry.line, offset_q);
        end else if (refill_done) begin
            // the word goes straight out of the incoming line.
            data_q <= select_word(mem_rsp.data, offset_q);
        end
    end

    always_comb begin
        cpu_rsp.data_valid = (state == cache_pkg::RESPOND);
        cpu_rsp.hit        = hit_q;
        cpu_rsp.busy       = (state == cache_pkg::LOOKUP) || (state == cache_pkg::REFILL);
        cpu_rsp.data       = data_q;
    end

    // the refill address is line aligned and held steady for the whole of REFILL.
    always_comb begin
        mem_req.req  = (state == cache_pkg::REFILL);
        mem_req.addr = {tag_q, index_q, {(cache_pkg::OFFSET_W + cache_pkg::BYTE_OFF_W){1'b0}}};
    end

endmodule

// ==== sim/cache_input.txt ====
# port (I or D), op (read or flush), byte address, expected hit, expected data
# flush lines ignore the port column, and each data word is its address xor 5a5a0000
I read 00001000 0 5a5a1000
D read 00020010 0 5a580010
I read 00001004 1 5a5a1004
D read 00020014 1 5a580014
I read 0000100c 1 5a5a100c
D read 0002001c 1 5a58001c
I read 00001008 1 5a5a1008
D read 00020018 1 5a580018
I read 00001006 1 5a5a1004
D read 00040020 0 5a5e0020
I read 00003008 0 5a5a3008
D read 00040024 1 5a5e0024
I read 00001000 0 5a5a1000
D read 00020010 1 5a580010
I read 00003004 0 5a5a3004
D read 00001000 0 5a5a1000
I read 00003000 1 5a5a3000
D flush 00000000 0 00000000
I read 00003000 0 5a5a3000
D read 00020014 0 5a580014
I read 0000300c 1 5a5a300c
D read 00020010 1 5a580010
I read 00001000 0 5a5a1000
D read 00040028 0 5a5e0028
I read 00001004 1 5a5a1004
D read 0004002c 1 5a5e002c

// ==== sim/mem_model.sv ====
`timescale 1ns/10ps

module mem_model (
    input  logic                clk,
    input  logic                rst,
    input  cache_pkg::mem_req_t mem_req,
    output cache_pkg::mem_rsp_t mem_rsp
);

    logic [31:0]      lcg_state;
    logic             pending;
    logic [3:0]       wait_cnt;
    cache_pkg::addr_t line_addr;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // the answer comes 2 to 9 cycles after the request is seen.
    function automatic logic [3:0] delay_from(input logic [31:0] s);
        logic [31:0] n;
        n = lcg_next(s);
        return 4'd2 + {1'b0, n[18:16]};
    endfunction

    // every word holds its own byte address xor a fixed pattern.
    function automatic cache_pkg::line_t line_for(input cache_pkg::addr_t base);
        cache_pkg::line_t line;
        for (int k = 0; k < cache_pkg::LINE_BITS / cache_pkg::WORD_W; k++) begin
            line[k * cache_pkg::WORD_W +: cache_pkg::WORD_W] = (base + 32'(4 * k)) ^ 32'h5A5A0000;
        end
        return line;
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lcg_state <= 32'd23796;
            pending   <= 1'b0;
            wait_cnt  <= '0;
            line_addr <= '0;
            mem_rsp   <= '0;
        end else begin
            mem_rsp.ready <= 1'b0;
            // req is still high on the edge that takes ready, so that edge starts nothing.
            if (!mem_rsp.ready) begin
                if (pending) begin
                    if (wait_cnt == 4'd1) begin
                        mem_rsp.ready <= 1'b1;
                        mem_rsp.data  <= line_for(line_addr);
                        pending       <= 1'b0;
                    end else begin
                        wait_cnt <= wait_cnt - 4'd1;
                    end
                end else if (mem_req.req) begin
                    lcg_state <= lcg_next(lcg_state);
                    wait_cnt  <= delay_from(lcg_state);
                    line_addr <= mem_req.addr;
                    pending   <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== sim/tb_cache_subsystem.sv ====
`timescale 1ns/10ps

module tb_cache_subsystem;

    localparam int RESET_CYCLES     = 10;
    localparam int CYCLES_PER_ENTRY = 40;
    localparam int MAX_ENTRIES      = 64;

    typedef struct packed {
        logic             is_flush;
        logic             port;
        cache_pkg::addr_t addr;
        logic             hit;
        cache_pkg::word_t data;
    } entry_t;

    // one outstanding read and the edge at which the cache took its strobe.
    typedef struct packed {
        cache_pkg::addr_t addr;
        logic             hit;
        cache_pkg::word_t data;
        int               issue;
    } expect_t;

    logic                clk;
    logic                rst;
    logic                flush;
    cache_pkg::cpu_req_t icache_req;
    cache_pkg::cpu_rsp_t icache_rsp;
    cache_pkg::cpu_req_t dcache_req;
    cache_pkg::cpu_rsp_t dcache_rsp;
    cache_pkg::mem_req_t mem_req;
    cache_pkg::mem_rsp_t mem_rsp;

    entry_t           entries [MAX_ENTRIES];
    int               num_entries = 0;
    int               cycle = 0;
    int               max_cycles = 0;
    int               value_errors = 0;
    int               order_errors = 0;
    int               protocol_errors = 0;
    expect_t          i_pending [$];
    expect_t          d_pending [$];
    cache_pkg::addr_t order_q [$];
    int               last_cycle [2] = '{-1, -1};
    logic             last_miss [2];
    cache_pkg::addr_t last_line [2];
    logic             dcache_won_last = 1'b1;
    logic             mem_req_seen = 1'b0;

    cache_subsystem UUT (.*);

    mem_model u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic load_entries();
        int               fd;
        int               n;
        logic [8*160-1:0] text;
        logic [8*8-1:0]   port_s;
        logic [8*8-1:0]   op_s;
        logic [31:0]      addr;
        logic [31:0]      hit;
        logic [31:0]      data;
        fd = $fopen("sim/cache_input.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && num_entries < MAX_ENTRIES) begin
                n = $fgets(text, fd);
                if (n > 0) begin
                    n = $sscanf(text, "%s %s %h %h %h", port_s, op_s, addr, hit, data);
                end
                if (n == 5) begin
                    entries[num_entries] = '{is_flush: (op_s == "flush"), port: (port_s == "D"),
                                             addr: addr, hit: hit[0], data: data};
                    num_entries++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic issue_read(input logic port, input entry_t e);
        expect_t x;
        x = '{addr: e.addr, hit: e.hit, data: e.data, issue: cycle + 1};
        if (port) begin
            dcache_req <= '{read_en: 1'b1, addr: e.addr};
            d_pending.push_back(x);
        end else begin
            icache_req <= '{read_en: 1'b1, addr: e.addr};
            i_pending.push_back(x);
        end
        // misses on both ports at one edge make a contest, and the winner alternates.
        last_cycle[port] = cycle;
        last_miss[port]  = !e.hit;
        last_line[port]  = {e.addr[31:4], 4'h0};
        if (!e.hit && last_cycle[!port] == cycle && last_miss[!port]) begin
            order_q.push_back(last_line[dcache_won_last ? 0 : 1]);
            order_q.push_back(last_line[dcache_won_last ? 1 : 0]);
            dcache_won_last = !dcache_won_last;
        end
        @(posedge clk);
        if (port) begin
            dcache_req.read_en <= 1'b0;
        end else begin
            icache_req.read_en <= 1'b0;
        end
    endtask

    task automatic run_port(input logic port, input int first, input int last);
        for (int k = first; k < last; k++) begin
            if (entries[k].port == port) begin
                @(posedge clk);
                while (port ? dcache_rsp.busy : icache_rsp.busy) begin
                    @(posedge clk);
                end
                issue_read(port, entries[k]);
            end
        end
    endtask

    task automatic check_response(input logic port, input cache_pkg::cpu_rsp_t rsp);
        expect_t x;
        int      waiting;
        waiting = port ? d_pending.size() : i_pending.size();
        assert (waiting > 0) else begin
            protocol_errors++;
            $display("data_valid on the %s port came without a request", port ? "D" : "I");
        end
        if (waiting > 0) begin
            if (port) begin
                x = d_pending.pop_front();
            end else begin
                x = i_pending.pop_front();
            end
            assert (rsp.hit == x.hit && rsp.data == x.data) else begin
                value_errors++;
                $display("** Error at %0t: %s %h got hit %0b data %h, expected %0b %h",
                         $time, port ? "D" : "I", x.addr, rsp.hit, rsp.data, x.hit, x.data);
            end
            assert (!x.hit || cycle - x.issue == 2) else begin
                value_errors++;
                $display("** Error at %0t: %s %h hit came %0d cycles after read_en",
                         $time, port ? "D" : "I", x.addr, cycle - x.issue);
            end
        end
    endtask

    // busy is high from the edge after the strobe is taken until data_valid.
    task automatic check_busy(input logic port, input logic busy);
        expect_t x;
        logic    want;
        want = 1'b0;
        if (port ? d_pending.size() > 0 : i_pending.size() > 0) begin
            x    = port ? d_pending[0] : i_pending[0];
            want = cycle > x.issue;
        end
        assert (busy == want) else begin
            protocol_errors++;
            $display("** Error at %0t: %s busy is %0b, expected %0b",
                     $time, port ? "D" : "I", busy, want);
        end
    endtask

    task automatic check_order(input cache_pkg::addr_t addr);
        cache_pkg::addr_t want;
        if (order_q.size() > 0) begin
            want = order_q.pop_front();
            assert (addr == want) else begin
                order_errors++;
                $display("** Error at %0t: memory got line %h, expected %h", $time, addr, want);
            end
        end
    endtask

    task automatic report_counts();
        $display("Errors: %0d value, %0d order, %0d protocol",
                 value_errors, order_errors, protocol_errors);
    endtask

    task automatic finish_run();
        assert (order_q.size() == 0) else begin
            protocol_errors++;
            $display("The memory never saw %0d line(s) of a contested miss pair", order_q.size());
        end
        report_counts();
        if (value_errors + order_errors + protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            if (icache_rsp.data_valid) begin
                check_response(1'b0, icache_rsp);
            end
            if (dcache_rsp.data_valid) begin
                check_response(1'b1, dcache_rsp);
            end
            check_busy(1'b0, icache_rsp.busy);
            check_busy(1'b1, dcache_rsp.busy);
            if (mem_req.req && !mem_req_seen) begin
                check_order(mem_req.addr);
            end
            mem_req_seen = mem_req.req;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (max_cycles > 0 && cycle >= max_cycles) begin
            $display("Timeout: the run did not end within %0d cycles", max_cycles);
            report_counts();
            $display("Verification failed");
            $finish;
        end
    end

    initial begin : main_flow
        int first;
        int last;
        rst        = 1'b0;
        flush      = 1'b0;
        icache_req = '0;
        dcache_req = '0;
        load_entries();
        if (num_entries == 0) begin
            $display("No accesses could be read from sim/cache_input.txt");
            report_counts();
            $display("Verification failed");
            $finish;
        end else begin
            max_cycles = CYCLES_PER_ENTRY * num_entries + RESET_CYCLES;
            repeat (RESET_CYCLES) @(posedge clk);
            rst <= 1'b1;
            first = 0;
            // each flush line closes a phase in which both ports run side by side.
            while (first < num_entries) begin
                last = first;
                while (last < num_entries && !entries[last].is_flush) begin
                    last++;
                end
                fork
                    run_port(1'b0, first, last);
                    run_port(1'b1, first, last);
                join
                @(posedge clk);
                while (i_pending.size() > 0 || d_pending.size() > 0) begin
                    @(posedge clk);
                end
                if (last < num_entries) begin
                    flush <= 1'b1;
                    @(posedge clk);
                    flush <= 1'b0;
                end
                first = last + 1;
            end
            finish_run();
        end
    end

endmodule
